// ==== verilog/const_decode_pkg.sv ====
// Shared types for the constant-decode stage: parcels, opcodes and constant sets
package const_decode_pkg;

	// ========================================================================
	// Basic widths
	// ========================================================================

	// One 64-bit operand constant as seen by the execution units
	typedef logic [63:0] word_t;

	// Instruction pointer of the bundle being decoded
	typedef logic [31:0] addr_t;

	// A raw instruction or postfix parcel
	typedef logic [47:0] parcel_t;

	// Number of postfix parcels consumed by one instruction
	typedef logic [2:0] postfix_count_t;

	// The 32-bit payload of a postfix starts at this bit
	localparam int POSTFIX_VALUE_LSB = 16;

	// ========================================================================
	// Opcodes
	// ========================================================================

	// Only the opcodes that carry or imply a constant are listed here
	typedef enum logic [7:0] {
		OP_ADDI    = 8'd4,
		OP_SUBFI   = 8'd5,
		OP_CMPI    = 8'd6,
		OP_CMPUI   = 8'd7,
		OP_ANDI    = 8'd8,
		OP_ORI     = 8'd9,
		OP_XORI    = 8'd10,
		OP_LOADI   = 8'd12,
		OP_LOAD    = 8'd64,
		OP_LDIP    = 8'd68,
		OP_STORE   = 8'd80,
		OP_FENCE   = 8'd120,
		// A parcel whose low byte holds this code extends the previous one
		OP_POSTFIX = 8'd127
	} op_t;

	// ========================================================================
	// Instruction and constant set layouts
	// ========================================================================

	// Instruction parcel, listed high field first so the opcode ends up in
	// the low byte. Loads and stores reuse imm24 as {disp16, rs2}
	typedef struct packed {
		logic [23:0] imm24;
		logic [7:0]  rs1;
		logic [7:0]  rd;
		op_t         opcode;
	} instr_t;

	// Up to four operand constants, each with its own presence flag
	typedef struct packed {
		word_t imm_a;
		word_t imm_b;
		word_t imm_c;
		word_t imm_d;
		logic  has_a;
		logic  has_b;
		logic  has_c;
		logic  has_d;
	} const_set_t;

endpackage

// ==== verilog/imm_field_decoder.sv ====
// Opcode-implied constant decoder: builds the base constant set of one instruction
`timescale 1ns/1ps

module imm_field_decoder import const_decode_pkg::*; (
	input  instr_t     instr,
	input  addr_t      ip,
	output const_set_t base
);

	// ========================================================================
	// Field extraction
	// ========================================================================

	// Memory operations pack the second source register into the low byte
	// of the immediate field and a 16-bit displacement above it
	logic [7:0]  rs2;
	logic [15:0] disp;

	// Common extensions of the 24-bit immediate
	word_t imm_sext;
	word_t imm_zext;
	word_t imm_oext;
	word_t disp_sext;

	assign rs2  = instr.imm24[7:0];
	assign disp = instr.imm24[23:8];

	assign imm_sext  = {{40{instr.imm24[23]}}, instr.imm24};
	assign imm_zext  = {40'd0, instr.imm24};
	// AND immediates fill the upper bits with ones so they keep those bits
	assign imm_oext  = {{40{1'b1}}, instr.imm24};
	assign disp_sext = {{48{disp[15]}}, disp};

	// ========================================================================
	// Opcode rules
	// ========================================================================

	always_comb begin
		// Anything not claimed by an opcode stays zero with its flag clear
		base = '0;

		case (instr.opcode)
			// Signed quick immediates
			OP_ADDI, OP_SUBFI, OP_CMPI: begin
				base.imm_b = imm_sext;
				base.has_b = 1'b1;
			end

			// Unsigned and bitwise quick immediates
			OP_CMPUI, OP_ORI, OP_XORI: begin
				base.imm_b = imm_zext;
				base.has_b = 1'b1;
			end

			OP_ANDI: begin
				base.imm_b = imm_oext;
				base.has_b = 1'b1;
			end

			// Load-immediate is an add to an implied zero register
			OP_LOADI: begin
				base.has_a = 1'b1;
				base.imm_b = imm_sext;
				base.has_b = 1'b1;
			end

			// Register zero reads as a constant zero operand
			OP_LOAD, OP_STORE: begin
				if (instr.rs1 == 8'd0) begin
					base.has_a = 1'b1;
				end
				if (rs2 == 8'd0) begin
					base.has_b = 1'b1;
				end
				base.imm_c = disp_sext;
				base.has_c = 1'b1;
			end

			// The instruction pointer replaces the base register
			OP_LDIP: begin
				base.imm_a = word_t'(ip);
				base.has_a = 1'b1;
				if (rs2 == 8'd0) begin
					base.has_b = 1'b1;
				end
				base.imm_c = disp_sext;
				base.has_c = 1'b1;
			end

			// Fence kind travels as an unsigned operand
			OP_FENCE: begin
				base.imm_b = imm_zext;
				base.has_b = 1'b1;
			end

			default: begin
				base = '0;
			end
		endcase
	end

endmodule

// ==== verilog/postfix_const_merger.sv ====
// Postfix scanner: applies the leading postfix parcels to the base constant set
`timescale 1ns/1ps

module postfix_const_merger import const_decode_pkg::*; #(
	parameter int max_postfix = 4
) (
	input  parcel_t [max_postfix-1:0] postfixes,
	input  const_set_t                base,
	output const_set_t                merged,
	output postfix_count_t            count
);

	// One bit per slot, set only while every slot before it is a postfix too
	logic [max_postfix-1:0] chain;

	// Mode 0 loads the sign-extended value, mode 1 replaces the upper half
	function automatic word_t apply_postfix(input word_t cur, input logic mode,
		input logic [31:0] value);
		word_t res;
		if (mode) begin
			res = {value, cur[31:0]};
		end else begin
			res = {{32{value[31]}}, value};
		end
		return res;
	endfunction

	// ========================================================================
	// Valid postfix chain
	// ========================================================================

	always_comb begin
		chain = '0;
		count = '0;
		for (int i = 0; i < max_postfix; i++) begin
			// A non-postfix slot breaks the chain for everything after it
			if (i == 0) begin
				chain[i] = (postfixes[i][7:0] == OP_POSTFIX);
			end else begin
				chain[i] = chain[i-1] && (postfixes[i][7:0] == OP_POSTFIX);
			end
			if (chain[i]) begin
				count = count + postfix_count_t'(1);
			end
		end
	end

	// ========================================================================
	// In-order merge
	// ========================================================================

	always_comb begin
		logic [1:0]  target;
		logic        mode;
		logic [31:0] value;

		merged = base;
		for (int i = 0; i < max_postfix; i++) begin
			target = postfixes[i][9:8];
			mode   = postfixes[i][10];
			value  = postfixes[i][POSTFIX_VALUE_LSB +: 32];
			// Later slots see the result of earlier ones, so the last write wins
			if (chain[i]) begin
				case (target)
					2'd0: begin
						merged.imm_a = apply_postfix(merged.imm_a, mode, value);
						merged.has_a = 1'b1;
					end
					2'd1: begin
						merged.imm_b = apply_postfix(merged.imm_b, mode, value);
						merged.has_b = 1'b1;
					end
					2'd2: begin
						merged.imm_c = apply_postfix(merged.imm_c, mode, value);
						merged.has_c = 1'b1;
					end
					default: begin
						merged.imm_d = apply_postfix(merged.imm_d, mode, value);
						merged.has_d = 1'b1;
					end
				endcase
			end
		end
	end

endmodule

// ==== verilog/const_decode_stage.sv ====
// Constant-decode stage: decodes and merges operand constants, registered once
`timescale 1ns/1ps

module const_decode_stage import const_decode_pkg::*; #(
	parameter int max_postfix = 4
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    in_valid,
	input  parcel_t [max_postfix:0] bundle,
	input  addr_t                   ip,
	output logic                    out_valid,
	output const_set_t              consts,
	output postfix_count_t          postfix_count
);

	// ========================================================================
	// Bundle split
	// ========================================================================

	// Parcel 0 is the instruction, the rest are candidate postfix slots
	instr_t                   instr;
	parcel_t [max_postfix-1:0] postfixes;

	// Opcode constants before and after postfix processing
	const_set_t     base;
	const_set_t     merged;
	postfix_count_t count;

	assign instr     = instr_t'(bundle[0]);
	assign postfixes = bundle[max_postfix:1];

	// ========================================================================
	// Combinational decode
	// ========================================================================

	imm_field_decoder imm_field_decoder_i (
		.instr (instr),
		.ip    (ip),
		.base  (base)
	);

	postfix_const_merger #(
		.max_postfix (max_postfix)
	) postfix_const_merger_i (
		.postfixes (postfixes),
		.base      (base),
		.merged    (merged),
		.count     (count)
	);

	// ========================================================================
	// Output register
	// ========================================================================

	// Results hold between valid inputs and the strobe lasts one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid     <= 1'b0;
			consts        <= '0;
			postfix_count <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				consts        <= merged;
				postfix_count <= count;
			end
		end
	end

endmodule

// ==== verification/const_decode_assert.sv ====
// Bound checks on the constant-decode stage: reset, valid latency and flag consistency
`timescale 1ns/1ps

module const_decode_assert import const_decode_pkg::*; (
	input logic           clk,
	input logic           arst_n,
	input logic           in_valid,
	input logic           out_valid,
	input const_set_t     consts,
	input postfix_count_t postfix_count
);

	// The bundle carries four postfix slots at most
	localparam postfix_count_t max_count = 3'd4;

	// The output register stays cleared while reset is held
	reset_clears_valid: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else $error("out_valid high while reset is asserted");

	// Exactly one cycle of latency from input strobe to output strobe
	valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(in_valid))
		else $error("out_valid does not follow in_valid by one cycle");

	// A constant without its flag must read as zero
	flag_a_zero: assert property (@(posedge clk) !consts.has_a |-> consts.imm_a == '0)
		else $error("imm_a nonzero with has_a clear");
	flag_b_zero: assert property (@(posedge clk) !consts.has_b |-> consts.imm_b == '0)
		else $error("imm_b nonzero with has_b clear");
	flag_c_zero: assert property (@(posedge clk) !consts.has_c |-> consts.imm_c == '0)
		else $error("imm_c nonzero with has_c clear");
	flag_d_zero: assert property (@(posedge clk) !consts.has_d |-> consts.imm_d == '0)
		else $error("imm_d nonzero with has_d clear");

	count_in_range: assert property (@(posedge clk) postfix_count <= max_count)
		else $error("postfix_count above the number of postfix slots");

endmodule

// ==== verification/const_decode_tb.sv ====
// Testbench for the constant-decode stage: table-driven bundles checked through a result queue
`timescale 1ns/1ps

module const_decode_tb import const_decode_pkg::*; ();

	localparam int max_postfix = 4;
	localparam int num_entries = 16;
	// Reset, sixteen rows, a few idle cycles and the drain fit well inside this
	localparam int max_cycles = 100;

	logic                    clk;
	logic                    arst_n;
	logic                    in_valid;
	parcel_t [max_postfix:0] bundle;
	addr_t                   ip;
	logic                    out_valid;
	const_set_t              consts;
	postfix_count_t          postfix_count;

	// One row per bundle together with its hand-worked result
	parcel_t [max_postfix:0] tbl_bundle [num_entries];
	addr_t                   tbl_ip [num_entries];
	const_set_t              tbl_consts [num_entries];
	postfix_count_t          tbl_count [num_entries];
	int                      tbl_idle [num_entries];
	int                      rows;

	// Results still owed by the DUT with the oldest at the front
	const_set_t     exp_consts_q[$];
	postfix_count_t exp_count_q[$];
	const_set_t     last_consts;
	logic           got_result;

	int mismatch_errors;
	int other_errors;
	int cycles;

	const_decode_stage #(
		.max_postfix (max_postfix)
	) const_decode_stage_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.bundle        (bundle),
		.ip            (ip),
		.out_valid     (out_valid),
		.consts        (consts),
		.postfix_count (postfix_count)
	);

	bind const_decode_stage const_decode_assert const_decode_assert_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.out_valid     (out_valid),
		.consts        (consts),
		.postfix_count (postfix_count)
	);

	always #5 clk = ~clk;

	// ========================================================================
	// Table construction
	// ========================================================================

	// Flags are given as {has_a, has_b, has_c, has_d}
	task automatic add_entry(input logic [7:0] op, input logic [7:0] rs1, input logic [7:0] rs2,
		input logic [23:0] imm24, input addr_t pc, input word_t a, input word_t b,
		input word_t c, input word_t d, input logic [3:0] has, input postfix_count_t cnt,
		input int idle);
		tbl_bundle[rows] = '0;
		// Instruction parcel is {imm24, rs1, rd, opcode} and rs2 fills the low immediate byte
		tbl_bundle[rows][0] = {imm24 | {16'd0, rs2}, rs1, 8'd1, op};
		tbl_ip[rows] = pc;
		tbl_consts[rows] = {a, b, c, d, has};
		tbl_count[rows] = cnt;
		tbl_idle[rows] = idle;
		rows++;
	endtask

	// Fills one postfix slot (1 to 4) of the row added last
	task automatic set_postfix(input int slot, input logic [1:0] target, input logic mode,
		input logic [31:0] value);
		tbl_bundle[rows-1][slot] = {value, 5'd0, mode, target, OP_POSTFIX};
	endtask

	task automatic build_table();
		// Quick immediates with sign, zero and one extension
		add_entry(OP_ADDI, 8'd1, 8'd0, 24'hFF_FF80, 32'h0, 64'h0, 64'hFFFF_FFFF_FFFF_FF80,
			64'h0, 64'h0, 4'b0100, 3'd0, 0);
		add_entry(OP_ORI, 8'd1, 8'd0, 24'h80_1234, 32'h0, 64'h0, 64'h0000_0000_0080_1234,
			64'h0, 64'h0, 4'b0100, 3'd0, 0);
		add_entry(OP_ANDI, 8'd1, 8'd0, 24'h00_F0F0, 32'h0, 64'h0, 64'hFFFF_FFFF_FF00_F0F0,
			64'h0, 64'h0, 4'b0100, 3'd0, 0);
		add_entry(OP_LOADI, 8'd1, 8'd0, 24'h12_3456, 32'h0, 64'h0, 64'h0000_0000_0012_3456,
			64'h0, 64'h0, 4'b1100, 3'd0, 2);
		// Memory operations with implied zero registers and the instruction pointer
		add_entry(OP_LOAD, 8'd0, 8'd0, 24'hFFF8_00, 32'h0, 64'h0, 64'h0,
			64'hFFFF_FFFF_FFFF_FFF8, 64'h0, 4'b1110, 3'd0, 0);
		add_entry(OP_STORE, 8'd3, 8'd4, 24'h0040_00, 32'h0, 64'h0, 64'h0,
			64'h40, 64'h0, 4'b0010, 3'd0, 0);
		add_entry(OP_LDIP, 8'd5, 8'd6, 24'h0100_00, 32'h8000_1000, 64'h8000_1000, 64'h0,
			64'h100, 64'h0, 4'b1010, 3'd0, 0);
		add_entry(OP_LDIP, 8'd0, 8'd0, 24'h8000_00, 32'h0000_2468, 64'h2468, 64'h0,
			64'hFFFF_FFFF_FFFF_8000, 64'h0, 4'b1110, 3'd0, 3);
		// One postfix in mode 0 aimed at imm_d
		add_entry(OP_ADDI, 8'd2, 8'd0, 24'h00_0010, 32'h0, 64'h0, 64'h10,
			64'h0, 64'hFFFF_FFFF_8765_4321, 4'b0101, 3'd1, 0);
		set_postfix(1, 2'd3, 1'b0, 32'h8765_4321);
		// Low half then high half builds a full 64-bit imm_b
		add_entry(OP_ORI, 8'd2, 8'd0, 24'h00_0001, 32'h0, 64'h0, 64'h0123_4567_89AB_CDEF,
			64'h0, 64'h0, 4'b0100, 3'd2, 0);
		set_postfix(1, 2'd1, 1'b0, 32'h89AB_CDEF);
		set_postfix(2, 2'd1, 1'b1, 32'h0123_4567);
		// The second postfix to imm_c wins
		add_entry(OP_ADDI, 8'd2, 8'd0, 24'h00_0005, 32'h0, 64'h0, 64'h5,
			64'hFFFF_FFFF_FFFF_FFFE, 64'h0, 4'b0110, 3'd2, 0);
		set_postfix(1, 2'd2, 1'b0, 32'h1111_1111);
		set_postfix(2, 2'd2, 1'b0, 32'hFFFF_FFFE);
		// Every slot holds a postfix
		add_entry(OP_FENCE, 8'd0, 8'd0, 24'h00_0003, 32'h0, 64'h10, 64'h20,
			64'hCAFE_0000_0000_0000, 64'h7FFF_FFFF, 4'b1111, 3'd4, 0);
		set_postfix(1, 2'd0, 1'b0, 32'h0000_0010);
		set_postfix(2, 2'd1, 1'b0, 32'h0000_0020);
		set_postfix(3, 2'd2, 1'b1, 32'hCAFE_0000);
		set_postfix(4, 2'd3, 1'b0, 32'h7FFF_FFFF);
		// Postfixes behind an empty first slot are ignored
		add_entry(OP_ADDI, 8'd2, 8'd0, 24'h00_0007, 32'h0, 64'h0, 64'h7,
			64'h0, 64'h0, 4'b0100, 3'd0, 1);
		set_postfix(2, 2'd3, 1'b0, 32'h0000_1234);
		set_postfix(3, 2'd0, 1'b0, 32'h0000_0001);
		add_entry(OP_LOADI, 8'd1, 8'd0, 24'h80_0000, 32'h0, 64'hDEAD_BEEF_0000_0000,
			64'hFFFF_FFFF_FF80_0000, 64'h0, 64'h0, 4'b1100, 3'd1, 0);
		set_postfix(1, 2'd0, 1'b1, 32'hDEAD_BEEF);
		set_postfix(3, 2'd1, 1'b0, 32'h0000_0001);
		// An unknown opcode gives a clean set that a postfix can still fill
		add_entry(8'd200, 8'd0, 8'd0, 24'hFF_FFFF, 32'h0, 64'h42, 64'h0,
			64'h0, 64'h0, 4'b1000, 3'd1, 0);
		set_postfix(1, 2'd0, 1'b0, 32'h0000_0042);
		add_entry(OP_SUBFI, 8'd1, 8'd0, 24'h80_0001, 32'h0, 64'h0, 64'hFFFF_FFFF_FF80_0001,
			64'h0, 64'h0, 4'b0100, 3'd0, 0);
	endtask

	// ========================================================================
	// Checking
	// ========================================================================

	task automatic check_field(input string name, input logic [63:0] got,
		input logic [63:0] want);
		assert (got === want) else begin
			mismatch_errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	// Outputs change on the rising edge, so they are sampled on the falling one
	always @(negedge clk) begin
		const_set_t     want;
		postfix_count_t want_count;

		if (arst_n && out_valid) begin
			assert (exp_consts_q.size() != 0) else begin
				other_errors++;
				$display("error at %0t: out_valid high with no result expected", $time);
			end
			if (exp_consts_q.size() != 0) begin
				want = exp_consts_q.pop_front();
				want_count = exp_count_q.pop_front();
				check_field("consts.imm_a", consts.imm_a, want.imm_a);
				check_field("consts.imm_b", consts.imm_b, want.imm_b);
				check_field("consts.imm_c", consts.imm_c, want.imm_c);
				check_field("consts.imm_d", consts.imm_d, want.imm_d);
				check_field("consts.has_a..has_d",
					64'({consts.has_a, consts.has_b, consts.has_c, consts.has_d}),
					64'({want.has_a, want.has_b, want.has_c, want.has_d}));
				check_field("postfix_count", 64'(postfix_count), 64'(want_count));
				last_consts = want;
				got_result = 1'b1;
			end
		end else if (arst_n) begin
			// Idle cycles keep the last result, which is zero straight after reset
			assert (consts === last_consts) else begin
				mismatch_errors++;
				$display("mismatch at %0t: consts got %h expected %h", $time, consts,
					last_consts);
			end
			// Until the first result the count still holds its reset value
			if (!got_result) begin
				assert (postfix_count === '0) else begin
					mismatch_errors++;
					$display("mismatch at %0t: postfix_count got %0d expected 0", $time,
						postfix_count);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			other_errors++;
			$display("error: run stopped after %0d cycles without finishing", cycles);
			$display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
			$display("Simulation failed");
			$finish;
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		clk = 1'b0;
		arst_n = 1'b1;
		in_valid = 1'b0;
		bundle = '0;
		ip = '0;
		rows = 0;
		mismatch_errors = 0;
		other_errors = 0;
		cycles = 0;
		last_consts = '0;
		got_result = 1'b0;
		build_table();

		// Reset falls just after time zero so the asynchronous clear sees an edge
		#1;
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		for (int i = 0; i < rows; i++) begin
			@(posedge clk);
			#1;
			in_valid = 1'b1;
			bundle = tbl_bundle[i];
			ip = tbl_ip[i];
			exp_consts_q.push_back(tbl_consts[i]);
			exp_count_q.push_back(tbl_count[i]);
			repeat (tbl_idle[i]) begin
				@(posedge clk);
				#1;
				in_valid = 1'b0;
				bundle = '0;
			end
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		bundle = '0;

		// The last result shows one edge later and the extra edges give it room
		repeat (3) @(posedge clk);
		assert (exp_consts_q.size() == 0) else begin
			other_errors++;
			$display("error: %0d expected results never appeared", exp_consts_q.size());
		end

		$display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
		if (mismatch_errors + other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/const_decode_pkg.sv
verilog/imm_field_decoder.sv
verilog/postfix_const_merger.sv
verilog/const_decode_stage.sv
verification/const_decode_assert.sv
verification/const_decode_tb.sv

// ==== Makefile ====
# Verilator build and run of the constant-decode stage testbench

SIM = obj_dir/const_decode_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f sources.f --top-module const_decode_tb \
		-Mdir obj_dir -o const_decode_sim

run: compile
	$(SIM) | tee sim.log
	@if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then \
		echo "Result: FAIL"; \
		exit 1; \
	fi
	@echo "Result: PASS"

clean:
	rm -rf obj_dir sim.log
